// File: filelist.f
+incdir+logic
logic/core_pkg.sv
logic/lifo.sv
logic/instr_fetch.sv
logic/execute.sv
logic/core.sv
tb/tb_clock.sv
tb/core_assert.sv
tb/core_tb.sv

// File: Makefile
SRCS := $(wildcard logic/*.sv logic/*.svh tb/*.sv)

.PHONY: run clean

run: obj_dir/Vcore_tb
	./obj_dir/Vcore_tb +verilator+error+limit+100

obj_dir/Vcore_tb: filelist.f $(SRCS)
	verilator --binary --timing --assert --top-module core_tb -f filelist.f -o Vcore_tb

clean:
	rm -rf obj_dir

// File: tb/core_tb.sv
//------------------------------
// Core testbench
// ROM program, data RAM model and run control
//------------------------------
`timescale 1ns/1ps
`include "core_defines.svh"

module core_tb;

	import core_pkg::*;

	localparam int    MEM_WORDS      = 1 << `CORE_ADDR_W;
	localparam addr_t LOOP_ADDR      = 9'd18;
	// Fetches from reset up to the self-loop
	localparam int    PROG_CYCLES    = 27;
	localparam int    TIMEOUT_CYCLES = 3 * PROG_CYCLES;

	logic                     clk;
	logic                     rst;
	logic [`CORE_INSTR_W-1:0] instr;
	addr_t                    instr_addr;
	logic                     mem_wr;
	addr_t                    mem_addr;
	word_t                    mem_data_in;
	word_t                    mem_data_out;

	logic [`CORE_INSTR_W-1:0] rom [MEM_WORDS];
	word_t                    ram [MEM_WORDS];
	int                       cycles;

	tb_clock u_clock (.clk(clk), .rst(rst));

	core u_dut (.*);

	// Galois LFSR with taps x^32+x^22+x^2+x+1
	function automatic logic [31:0] lfsr_step(logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	function automatic logic [`CORE_INSTR_W-1:0] encode(opcode_e op, operand_t opr);
		return {op, opr};
	endfunction

	task automatic stop_with_failure(string why);
		$display("Finished with errors");
		$fatal(1, "%s", why);
	endtask

	// ROM and RAM -----------------
	initial begin : memories
		logic [31:0] lfsr;
		addr_t       fetch_a;
		addr_t       data_a;
		logic        in_rst;
		logic        wr;
		word_t       wdata;
		instr       = encode(OP_NOP, '0);
		mem_data_in = '0;
		lfsr        = 32'hbf9755e1;
		// One LFSR step per RAM bit
		for (int a = 0; a < MEM_WORDS; a++) begin
			for (int b = 0; b < `CORE_WORD_W; b++) begin
				ram[a][b] = lfsr[0];
				lfsr      = lfsr_step(lfsr);
			end
			rom[a] = encode(OP_NOP, '0);
		end
		// Odd word for the JIZ fall-through
		ram[9'h013][0] = 1'b1;
		// Main line
		rom[0]  = encode(OP_LOD, 9'h010);
		rom[1]  = encode(OP_ADD, 9'h011);
		rom[2]  = encode(OP_STO, 9'h040);
		rom[3]  = encode(OP_PSH, 9'h000);
		rom[4]  = encode(OP_XOR, 9'h012);
		rom[5]  = encode(OP_LOD, 9'h040);
		rom[6]  = encode(OP_PAD, 9'h000);
		rom[7]  = encode(OP_CAL, 9'd32);
		rom[8]  = encode(OP_STO, 9'h041);
		rom[9]  = encode(OP_JMP, 9'd24);
		// Zero then taken JIZ
		rom[10] = encode(OP_LOD, 9'h010);
		rom[11] = encode(OP_XOR, 9'h010);
		rom[12] = encode(OP_JIZ, 9'd15);
		rom[13] = encode(OP_STO, 9'h042);
		rom[14] = encode(OP_NOP, 9'h000);
		// Odd then JIZ falls through
		rom[15] = encode(OP_LOD, 9'h013);
		rom[16] = encode(OP_JIZ, 9'd13);
		rom[17] = encode(OP_STO, 9'h043);
		rom[18] = encode(OP_JMP, LOOP_ADDR);
		// Detour so the address after a JMP target is fetched
		rom[24] = encode(OP_NOP, 9'h000);
		rom[25] = encode(OP_JMP, 9'd10);
		// Outer subroutine
		rom[32] = encode(OP_ADD, 9'h014);
		rom[33] = encode(OP_PSH, 9'h000);
		rom[34] = encode(OP_CAL, 9'd48);
		rom[35] = encode(OP_PAD, 9'h000);
		rom[36] = encode(OP_RET, 9'h000);
		// Inner subroutine
		rom[48] = encode(OP_XOR, 9'h015);
		rom[49] = encode(OP_STO, 9'h044);
		rom[50] = encode(OP_RET, 9'h000);
		forever begin
			@(posedge clk);
			// Port state as it stood at the edge
			fetch_a = instr_addr;
			data_a  = mem_addr;
			in_rst  = rst;
			wr      = mem_wr;
			wdata   = mem_data_out;
			#0.5;
			instr       = in_rst ? encode(OP_NOP, '0) : rom[fetch_a];
			// Read before write
			mem_data_in = ram[data_a];
			if (wr) begin
				ram[data_a] = wdata;
			end
		end
	end

	// Run control -----------------
	initial begin
		cycles = 0;
		@(posedge clk);
		wait (rst == 1'b0);
		while (instr_addr != LOOP_ADDR) begin
			@(posedge clk);
			#1;
			cycles++;
			if (u_dut.u_assert.fail_flag) begin
				stop_with_failure("a core check failed as reported above");
			end
			if (cycles > TIMEOUT_CYCLES) begin
				stop_with_failure("timeout because the program never reached its self-loop");
			end
		end
		// A few turns of the self-loop
		repeat (4) @(posedge clk);
		#1;
		if (u_dut.u_assert.fail_flag) begin
			stop_with_failure("a core check failed as reported above");
		end else begin
			$display("Finished with no errors");
			$finish;
		end
	end

endmodule

// File: tb/core_assert.sv
//------------------------------
// Core checker
// Reference model of fetch and accumulator
//------------------------------
`timescale 1ns/1ps
`include "core_defines.svh"

module core_assert (
	input logic                     clk,
	input logic                     rst,
	input logic [`CORE_INSTR_W-1:0] instr,
	input core_pkg::addr_t          instr_addr,
	input logic                     mem_wr,
	input core_pkg::addr_t          mem_addr,
	input core_pkg::word_t          mem_data_in,
	input core_pkg::word_t          mem_data_out
);

	import core_pkg::*;

	localparam int RSP_W = $clog2(`CORE_RSTACK_DEPTH);
	localparam int DSP_W = $clog2(`CORE_DSTACK_DEPTH);
	localparam int WORDS = 1 << `CORE_ADDR_W;

	// Raised by any failed assertion
	logic fail_flag = 1'b0;

	// Model state -----------------
	addr_t            m_pc;
	opcode_e          m_op;
	operand_t         m_opr;
	word_t            m_acc;
	addr_t            m_rstack [`CORE_RSTACK_DEPTH];
	logic [RSP_W-1:0] m_rsp;
	word_t            m_dstack [`CORE_DSTACK_DEPTH];
	logic [DSP_W-1:0] m_dsp;
	// Words stored by STO so far
	word_t            shadow [WORDS];
	logic [WORDS-1:0] written;

	opcode_e  f_op;
	operand_t f_opr;
	word_t    rd_data;
	word_t    exp_alu;
	addr_t    exp_addr;

	// Instruction on the ROM output
	assign f_op  = opcode_e'(instr[`CORE_INSTR_W-1 -: `CORE_OPCODE_W]);
	assign f_opr = instr[`CORE_OPERAND_W-1:0];

	// Result of the instruction in execute
	always_comb begin
		rd_data = written[m_opr] ? shadow[m_opr] : mem_data_in;
		case (m_op)
			OP_LOD: exp_alu = rd_data;
			OP_ADD: exp_alu = m_acc + rd_data;
			OP_XOR: exp_alu = m_acc ^ rd_data;
			OP_PAD: exp_alu = m_acc + m_dstack[m_dsp - 1'b1];
			default: exp_alu = m_acc;
		endcase
	end

	// Expected fetch address
	always_comb begin
		if (f_op == OP_RET) begin
			exp_addr = m_rstack[m_rsp - 1'b1];
		end else if (f_op == OP_JMP || f_op == OP_CAL ||
			(f_op == OP_JIZ && !exp_alu[0])) begin
			exp_addr = addr_t'(f_opr);
		end else begin
			exp_addr = m_pc;
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			m_pc    <= '0;
			m_op    <= OP_NOP;
			m_opr   <= '0;
			m_acc   <= '0;
			m_rsp   <= '0;
			m_dsp   <= '0;
			written <= '0;
		end else begin
			m_pc  <= exp_addr + 1'b1;
			m_op  <= f_op;
			m_opr <= f_opr;
			m_acc <= exp_alu;
			// Return address is the one after the CAL
			if (f_op == OP_CAL) begin
				m_rstack[m_rsp] <= m_pc;
				m_rsp           <= m_rsp + 1'b1;
			end else if (f_op == OP_RET) begin
				m_rsp <= m_rsp - 1'b1;
			end
			if (m_op == OP_PSH) begin
				m_dstack[m_dsp] <= m_acc;
				m_dsp           <= m_dsp + 1'b1;
			end else if (m_op == OP_PAD) begin
				m_dsp <= m_dsp - 1'b1;
			end
			if (m_op == OP_STO) begin
				shadow[m_opr]  <= m_acc;
				written[m_opr] <= 1'b1;
			end
		end
	end

	// Checks ----------------------
	a_fetch_addr: assert property (@(posedge clk) disable iff (rst)
		instr_addr == exp_addr)
	else begin
		fail_flag = 1'b1;
		$error("MISMATCH instr_addr expected %h got %h",
			$sampled(exp_addr), $sampled(instr_addr));
	end

	// Write only while STO executes
	a_wr_only_sto: assert property (@(posedge clk) disable iff (rst)
		mem_wr == (m_op == OP_STO))
	else begin
		fail_flag = 1'b1;
		$error("MISMATCH mem_wr expected %h got %h",
			$sampled(m_op == OP_STO), $sampled(mem_wr));
	end

	a_sto_addr: assert property (@(posedge clk) disable iff (rst)
		mem_wr |-> mem_addr == addr_t'(m_opr))
	else begin
		fail_flag = 1'b1;
		$error("MISMATCH mem_addr expected %h got %h",
			$sampled(m_opr), $sampled(mem_addr));
	end

	// Read address follows the operand being fetched
	a_rd_addr: assert property (@(posedge clk) disable iff (rst)
		(m_op != OP_STO) |-> mem_addr == addr_t'(f_opr))
	else begin
		fail_flag = 1'b1;
		$error("MISMATCH mem_addr expected %h got %h",
			$sampled(f_opr), $sampled(mem_addr));
	end

	// Accumulator checked every cycle including stored words
	a_acc: assert property (@(posedge clk) disable iff (rst)
		mem_data_out == m_acc)
	else begin
		fail_flag = 1'b1;
		$error("MISMATCH mem_data_out expected %h got %h",
			$sampled(m_acc), $sampled(mem_data_out));
	end

endmodule

bind core core_assert u_assert (.*);

// File: tb/tb_clock.sv
//------------------------------
// Testbench clock and reset
//------------------------------
`timescale 1ns/1ps

module tb_clock #(
	parameter int RESET_CYCLES = 16
) (
	output logic clk,
	output logic rst
);

	// 4 ns period
	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// Reset drops just after an edge
	initial begin
		rst = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		#0.5 rst = 1'b0;
	end

endmodule

// File: logic/core.sv
//------------------------------
// Processor core top
// Fetch and execute wired to the memory ports
//------------------------------
`timescale 1ns/1ps
`include "core_defines.svh"

module core (
	input  logic                     clk,
	input  logic                     rst,
	input  logic [`CORE_INSTR_W-1:0] instr,
	output core_pkg::addr_t          instr_addr,
	output logic                     mem_wr,
	output core_pkg::addr_t          mem_addr,
	input  core_pkg::word_t          mem_data_in,
	output core_pkg::word_t          mem_data_out
);

	import core_pkg::*;

	// Fetch to execute
	opcode_e  fe_opcode;
	operand_t fe_operand;
	// Execute back to fetch
	logic     ex_acc_lsb;

	// Fetch -----------------------
	instr_fetch u_fetch (
		.clk       (clk),
		.rst       (rst),
		.instr     (instr),
		.acc_lsb   (ex_acc_lsb),
		.instr_addr(instr_addr),
		.opcode    (fe_opcode),
		.operand   (fe_operand)
	);

	// Execute ---------------------
	execute u_exec (
		.clk         (clk),
		.rst         (rst),
		.opcode      (fe_opcode),
		.operand     (fe_operand),
		.mem_data_in (mem_data_in),
		.mem_wr      (mem_wr),
		.mem_addr    (mem_addr),
		.mem_data_out(mem_data_out),
		.acc_lsb     (ex_acc_lsb)
	);

endmodule

// File: logic/execute.sv
//------------------------------
// Execute stage
// Registered decode, ALU, accumulator, data stack
//------------------------------
`timescale 1ns/1ps
`include "core_defines.svh"

module execute (
	input  logic               clk,
	input  logic               rst,
	input  core_pkg::opcode_e  opcode,
	input  core_pkg::operand_t operand,
	input  core_pkg::word_t    mem_data_in,
	output logic               mem_wr,
	output core_pkg::addr_t    mem_addr,
	output core_pkg::word_t    mem_data_out,
	output logic               acc_lsb
);

	import core_pkg::*;

	// Instruction in its execute cycle
	opcode_e  op_q;
	operand_t operand_q;

	word_t acc;
	word_t alu_out;
	word_t dstack_top;

	logic is_sto;
	logic is_psh;
	logic is_pad;

	// Decode register -------------
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			op_q <= OP_NOP;
		end else begin
			op_q <= opcode;
		end
	end

	always_ff @(posedge clk) begin
		operand_q <= operand;
	end

	assign is_sto = (op_q == OP_STO);
	assign is_psh = (op_q == OP_PSH);
	assign is_pad = (op_q == OP_PAD);

	// Memory port -----------------
	// Read address runs a cycle early for the synchronous RAM
	assign mem_addr     = is_sto ? addr_t'(operand_q) : addr_t'(operand);
	assign mem_wr       = is_sto;
	assign mem_data_out = acc;

	// ALU -------------------------
	always_comb begin
		case (op_q)
			OP_LOD: alu_out = mem_data_in;
			OP_ADD: alu_out = acc + mem_data_in;
			OP_XOR: alu_out = acc ^ mem_data_in;
			OP_PAD: alu_out = acc + dstack_top;
			// STO, PSH, NOP and branches hold the value
			default: alu_out = acc;
		endcase
	end

	// Fetch needs this for JIZ
	assign acc_lsb = alu_out[0];

	// Accumulator
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			acc <= '0;
		end else begin
			acc <= alu_out;
		end
	end

	// Data stack ------------------
	lifo #(
		.payload_t(word_t),
		.DEPTH    (`CORE_DSTACK_DEPTH)
	) u_dstack (
		.clk (clk),
		.rst (rst),
		.push(is_psh),
		.pop (is_pad),
		.din (acc),
		.top (dstack_top)
	);

endmodule

// File: logic/instr_fetch.sv
//------------------------------
// Instruction fetch
// Program counter, branch prefetch and return stack
//------------------------------
`timescale 1ns/1ps
`include "core_defines.svh"

module instr_fetch (
	input  logic                     clk,
	input  logic                     rst,
	input  logic [`CORE_INSTR_W-1:0] instr,
	input  logic                     acc_lsb,
	output core_pkg::addr_t          instr_addr,
	output core_pkg::opcode_e        opcode,
	output core_pkg::operand_t       operand
);

	import core_pkg::*;

	// Address after the instruction on instr
	addr_t pc;
	// Return address from the stack
	addr_t ret_addr;

	logic is_jmp;
	logic is_jiz;
	logic is_cal;
	logic is_ret;
	logic take_operand;

	// Field split -----------------
	assign opcode  = opcode_e'(instr[`CORE_INSTR_W-1 -: `CORE_OPCODE_W]);
	assign operand = instr[`CORE_OPERAND_W-1:0];

	// Flow control decode
	assign is_jmp = (opcode == OP_JMP);
	assign is_jiz = (opcode == OP_JIZ);
	assign is_cal = (opcode == OP_CAL);
	assign is_ret = (opcode == OP_RET);

	// JIZ looks at the ALU result of the instruction now executing
	assign take_operand = is_jmp | is_cal | (is_jiz & ~acc_lsb);

	// Next address ----------------
	always_comb begin
		if (is_ret) begin
			instr_addr = ret_addr;
		end else if (take_operand) begin
			instr_addr = addr_t'(operand);
		end else begin
			instr_addr = pc;
		end
	end

	// PC runs one ahead of the chosen address
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			pc <= '0;
		end else begin
			pc <= instr_addr + 1'b1;
		end
	end

	// Return stack ----------------
	// CAL saves the address after itself, RET pops it
	lifo #(
		.payload_t(addr_t),
		.DEPTH    (`CORE_RSTACK_DEPTH)
	) u_rstack (
		.clk (clk),
		.rst (rst),
		.push(is_cal),
		.pop (is_ret),
		.din (pc),
		.top (ret_addr)
	);

endmodule

// File: logic/lifo.sv
//------------------------------
// LIFO stack
// Pointer plus memory, top read combinationally
//------------------------------
`timescale 1ns/1ps

module lifo #(
	parameter type payload_t = logic [7:0],
	parameter int  DEPTH     = 8
) (
	input  logic     clk,
	input  logic     rst,
	input  logic     push,
	input  logic     pop,
	input  payload_t din,
	output payload_t top
);

	// Pointer wide enough to index DEPTH entries
	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

	// Pointer to the next free slot
	logic [PTR_W-1:0] ptr;
	payload_t         mem [DEPTH];

	// Pointer ---------------------
	// Push wins if both arrive together
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			ptr <= '0;
		end else if (push) begin
			ptr <= ptr + 1'b1;
		end else if (pop) begin
			ptr <= ptr - 1'b1;
		end
	end

	// Storage ---------------------
	always_ff @(posedge clk) begin
		if (push) begin
			mem[ptr] <= din;
		end
	end

	// Last pushed entry sits one below the pointer
	assign top = mem[ptr - 1'b1];

endmodule

// File: logic/core_pkg.sv
//------------------------------
// Core types
// Address, word, operand and opcode types
//------------------------------
`include "core_defines.svh"

package core_pkg;

	// Instruction and data address
	typedef logic [`CORE_ADDR_W-1:0] addr_t;

	// Data word, accumulator and stack payload
	typedef logic [`CORE_WORD_W-1:0] word_t;

	// Immediate field of an instruction
	typedef logic [`CORE_OPERAND_W-1:0] operand_t;

	// Opcode set ------------------
	// Codes outside the list behave as NOP
	typedef enum logic [`CORE_OPCODE_W-1:0] {
		OP_NOP = `CORE_OP_NOP,
		OP_LOD = `CORE_OP_LOD,
		OP_STO = `CORE_OP_STO,
		OP_ADD = `CORE_OP_ADD,
		OP_XOR = `CORE_OP_XOR,
		OP_PSH = `CORE_OP_PSH,
		OP_PAD = `CORE_OP_PAD,
		OP_JMP = `CORE_OP_JMP,
		OP_JIZ = `CORE_OP_JIZ,
		OP_CAL = `CORE_OP_CAL,
		OP_RET = `CORE_OP_RET
	} opcode_e;

endpackage

// File: logic/core_defines.svh
//------------------------------
// Core configuration macros
// Field widths, stack depths and opcode values
//------------------------------
`ifndef CORE_DEFINES_SVH
`define CORE_DEFINES_SVH

// Instruction fields ----------
// Opcode sits in the upper bits, operand in the lower
`define CORE_OPCODE_W     7
`define CORE_OPERAND_W    9
`define CORE_INSTR_W      16

// Datapath widths -------------
`define CORE_ADDR_W       9
`define CORE_WORD_W       16

// Stack depths
`define CORE_RSTACK_DEPTH 8
`define CORE_DSTACK_DEPTH 8

// Opcode values ---------------
`define CORE_OP_NOP       0
`define CORE_OP_LOD       1
`define CORE_OP_STO       2
`define CORE_OP_ADD       3
`define CORE_OP_XOR       4
`define CORE_OP_PSH       5
`define CORE_OP_PAD       6
// Flow control, handled in fetch
`define CORE_OP_JMP       12
`define CORE_OP_JIZ       13
`define CORE_OP_CAL       14
`define CORE_OP_RET       15

`endif
